// File: flist.f
hdl/fpcvt_pkg.sv
hdl/cvt_result_if.sv
hdl/fp64_to_int64.sv
hdl/int64_to_fp64.sv
hdl/result_arbiter.sv
hdl/fpcvt_top.sv
tb/fpcvt_tb.sv

// File: hdl/cvt_result_if.sv
`timescale 1ns/10ps

interface cvt_result_if #(
    parameter int TAG_W = 4
);
    import fpcvt_pkg::*;

    // Result handshake
    logic valid;
    logic ready;

    // Result payload
    logic [63:0]       data;
    logic [FLAG_W-1:0] flags;
    logic [TAG_W-1:0]  tag;

    // Converter side
    modport src (
        output valid,
        output data,
        output flags,
        output tag,
        input  ready
    );

    // Arbiter side
    modport snk (
        input  valid,
        input  data,
        input  flags,
        input  tag,
        output ready
    );

endinterface

// File: hdl/fp64_to_int64.sv
`timescale 1ns/10ps

module fp64_to_int64 #(
    parameter int TAG_W = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  fpcvt_pkg::fp64_word_u in_data,
    input  logic [TAG_W-1:0]      in_tag,
    cvt_result_if.src             res
);
    import fpcvt_pkg::*;

    logic               sign;
    logic [10:0]        exp_b;
    logic [51:0]        mant;
    logic               is_nan;
    logic               is_inf;
    logic               is_zero;
    logic signed [12:0] exp_unb;
    logic               below_one;
    logic [115:0]       shifted;
    logic [63:0]        int_mag;
    logic [51:0]        frac_bits;
    logic               too_big;
    logic [63:0]        nxt_data;
    logic [FLAG_W-1:0]  nxt_flags;
    logic               accept;

    // Field decode through the float view
    assign sign  = in_data.as_fp.sign;
    assign exp_b = in_data.as_fp.exp;
    assign mant  = in_data.as_fp.mant;

    assign is_nan  = (exp_b == 11'h7ff) && (mant != '0);
    assign is_inf  = (exp_b == 11'h7ff) && (mant == '0);
    assign is_zero = (exp_b == '0) && (mant == '0);

    // Unbiased exponent, negative below 1.0 (denormals land here too)
    assign exp_unb   = 13'(exp_b) - 13'(FP64_BIAS);
    assign below_one = exp_unb < 13'sd0;

    // Binary point sits between bits 52 and 51 after the shift
    assign shifted   = {63'd0, 1'b1, mant} << exp_unb[5:0];
    assign int_mag   = shifted[115:52];
    assign frac_bits = shifted[51:0];

    // Only -2^63 may use the top bit
    // Shift result means nothing below 1.0
    assign too_big = !below_one && ((exp_unb > 13'sd63)
                   || (int_mag[63] && !(sign && (int_mag[62:0] == '0))));

    always_comb begin
        nxt_data  = '0;
        nxt_flags = '0;
        if (is_nan) begin
            nxt_flags[FLAG_INVALID] = 1'b1;
        end else if (is_inf || too_big) begin
            nxt_data                 = sign ? INT64_MIN_C : INT64_MAX_C;
            nxt_flags[FLAG_OVERFLOW] = 1'b1;
        end else if (below_one) begin
            // Truncates to zero, inexact unless the input was zero
            nxt_flags[FLAG_INEXACT] = !is_zero;
        end else begin
            nxt_data                = sign ? -int_mag : int_mag;
            nxt_flags[FLAG_INEXACT] = |frac_bits;
        end
    end

    // Accept when empty or draining this cycle
    assign in_ready = !res.valid || res.ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else if (accept) begin
            res.valid <= 1'b1;
        end else if (res.ready) begin
            res.valid <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (accept) begin
            res.data  <= nxt_data;
            res.flags <= nxt_flags;
            res.tag   <= in_tag;
        end
    end

    // Stalled result must hold until taken
    a_hold: assert property (@(posedge clk) disable iff (rst)
        res.valid && !res.ready |=> res.valid && $stable(res.data)
                                    && $stable(res.flags) && $stable(res.tag));

    a_flags: assert property (@(posedge clk) disable iff (rst)
        res.valid |-> !(res.flags[FLAG_INVALID] && res.flags[FLAG_OVERFLOW]));

endmodule

// File: hdl/fpcvt_pkg.sv
package fpcvt_pkg;

    // Flag vector layout
    localparam int FLAG_W        = 3;
    localparam int FLAG_INVALID  = 2;
    localparam int FLAG_OVERFLOW = 1;
    localparam int FLAG_INEXACT  = 0;

    // Binary64 exponent bias
    localparam int FP64_BIAS = 1023;

    // Signed 64-bit saturation limits
    localparam logic [63:0] INT64_MAX_C = 64'h7fff_ffff_ffff_ffff;
    localparam logic [63:0] INT64_MIN_C = 64'h8000_0000_0000_0000;

    // Binary64 field split
    typedef struct packed {
        logic        sign;
        logic [10:0] exp;
        logic [51:0] mant;
    } fp64_fields_t;

    // One operand word, read as float fields or as a signed integer
    typedef union packed {
        fp64_fields_t       as_fp;
        logic signed [63:0] as_int;
    } fp64_word_u;

endpackage

// File: hdl/fpcvt_top.sv
`timescale 1ns/10ps

module fpcvt_top #(
    parameter int TAG_W = 4
) (
    input  logic                         clk,
    input  logic                         rst,

    // Float to integer request
    input  logic                         f2i_valid,
    output logic                         f2i_ready,
    input  logic [63:0]                  f2i_data,
    input  logic [TAG_W-1:0]             f2i_tag,

    // Integer to float request
    input  logic                         i2f_valid,
    output logic                         i2f_ready,
    input  logic [63:0]                  i2f_data,
    input  logic [TAG_W-1:0]             i2f_tag,

    // Shared result bus
    output logic                         res_valid,
    input  logic                         res_ready,
    output logic [63:0]                  res_data,
    output logic [fpcvt_pkg::FLAG_W-1:0] res_flags,
    output logic [TAG_W-1:0]             res_tag,
    output logic                         res_src
);

    // One result link per converter
    cvt_result_if #(.TAG_W(TAG_W)) f2i_res ();
    cvt_result_if #(.TAG_W(TAG_W)) i2f_res ();

    fp64_to_int64 #(.TAG_W(TAG_W)) u_f2i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (f2i_valid),
        .in_ready (f2i_ready),
        .in_data  (f2i_data),
        .in_tag   (f2i_tag),
        .res      (f2i_res.src)
    );

    int64_to_fp64 #(.TAG_W(TAG_W)) u_i2f (
        .clk      (clk),
        .rst      (rst),
        .in_valid (i2f_valid),
        .in_ready (i2f_ready),
        .in_data  (i2f_data),
        .in_tag   (i2f_tag),
        .res      (i2f_res.src)
    );

    // Source 0 is float to integer
    result_arbiter #(.TAG_W(TAG_W)) u_arb (
        .clk       (clk),
        .rst       (rst),
        .req0      (f2i_res.snk),
        .req1      (i2f_res.snk),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_flags (res_flags),
        .res_tag   (res_tag),
        .res_src   (res_src)
    );

endmodule

// File: hdl/int64_to_fp64.sv
`timescale 1ns/10ps

module int64_to_fp64 #(
    parameter int TAG_W = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  fpcvt_pkg::fp64_word_u in_data,
    input  logic [TAG_W-1:0]      in_tag,
    cvt_result_if.src             res
);
    import fpcvt_pkg::*;

    logic              neg;
    logic [63:0]       mag;
    logic [5:0]        lead;
    logic [63:0]       norm;
    fp64_word_u        nxt_word;
    logic [FLAG_W-1:0] nxt_flags;
    logic              accept;
    fp64_word_u        res_word;

    // Sign and magnitude from the integer view
    assign neg = in_data.as_int[63];
    // -2^63 negates to itself, which is the right magnitude
    assign mag = neg ? 64'(-in_data.as_int) : 64'(in_data.as_int);

    // Leading-one position, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                lead = 6'(i);
            end
        end
    end

    // Leading one moved to bit 63
    assign norm = mag << (6'd63 - lead);

    always_comb begin
        // Zero input stays all zeros (positive zero)
        nxt_word  = '0;
        nxt_flags = '0;
        if (mag != '0) begin
            nxt_word.as_fp.sign = neg;
            nxt_word.as_fp.exp  = 11'(FP64_BIAS) + 11'(lead);
            // Hidden bit at 63, keep the next 52
            nxt_word.as_fp.mant = norm[62:11];
            // Anything left below is cut off
            nxt_flags[FLAG_INEXACT] = |norm[10:0];
        end
    end

    // Same one-deep register as the other converter
    assign in_ready = !res.valid || res.ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else if (accept) begin
            res.valid <= 1'b1;
        end else if (res.ready) begin
            res.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res.data  <= nxt_word;
            res.flags <= nxt_flags;
            res.tag   <= in_tag;
        end
    end

    // Float view of the held result
    assign res_word = res.data;

    a_hold: assert property (@(posedge clk) disable iff (rst)
        res.valid && !res.ready |=> res.valid && $stable(res.data)
                                    && $stable(res.flags) && $stable(res.tag));

    // Largest exponent is bias + 63
    a_exp: assert property (@(posedge clk) disable iff (rst)
        res.valid |-> res_word.as_fp.exp != 11'h7ff);

endmodule

// File: hdl/result_arbiter.sv
`timescale 1ns/10ps

module result_arbiter #(
    parameter int TAG_W = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    cvt_result_if.snk                    req0,
    cvt_result_if.snk                    req1,
    output logic                         res_valid,
    input  logic                         res_ready,
    output logic [63:0]                  res_data,
    output logic [fpcvt_pkg::FLAG_W-1:0] res_flags,
    output logic [TAG_W-1:0]             res_tag,
    output logic                         res_src
);

    // Priority pointer, set means source 1 goes first
    logic prio;
    logic grant1;
    logic xfer;

    // Lone requester wins at once, otherwise the pointer decides
    assign grant1 = req1.valid && (!req0.valid || prio);

    assign res_valid = req0.valid || req1.valid;
    assign res_src   = grant1;
    assign res_data  = grant1 ? req1.data  : req0.data;
    assign res_flags = grant1 ? req1.flags : req0.flags;
    assign res_tag   = grant1 ? req1.tag   : req0.tag;

    // Ready back to the granted source only
    assign req0.ready = res_ready && !grant1;
    assign req1.ready = res_ready && grant1;

    assign xfer = res_valid && res_ready;

    // Loser of each transfer goes first next time
    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= 1'b0;
        end else if (xfer) begin
            prio <= !grant1;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        !(req0.ready && req1.ready));

    // Granted source is the one holding a result
    a_valid_src: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> (res_src ? req1.valid : req0.valid));

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fpcvt_tb \
    -f flist.f \
    -o fpcvt_sim

./obj_dir/fpcvt_sim | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

// File: tb/fpcvt_tb.sv
`timescale 1ns/10ps

module fpcvt_tb;
    import fpcvt_pkg::*;

    localparam int TAG_W  = 4;
    localparam int N_RAND = 60;
    localparam int N_BUS  = 150;
    // Bus test needs near 600 cycles at half stall, directed tests a few hundred
    localparam int MAX_CYC = 4000;

    typedef logic [64+FLAG_W+TAG_W-1:0] exp_t;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic              f2i_valid = 1'b0;
    logic              f2i_ready;
    logic [63:0]       f2i_data = '0;
    logic [TAG_W-1:0]  f2i_tag = '0;
    logic              i2f_valid = 1'b0;
    logic              i2f_ready;
    logic [63:0]       i2f_data = '0;
    logic [TAG_W-1:0]  i2f_tag = '0;
    logic              res_valid;
    logic              res_ready = 1'b1;
    logic [63:0]       res_data;
    logic [FLAG_W-1:0] res_flags;
    logic [TAG_W-1:0]  res_tag;
    logic              res_src;

    // Expected results per source, oldest first
    exp_t                   exp_q0[$];
    exp_t                   exp_q1[$];
    logic [1:0][63:0]       head_data;
    logic [1:0][FLAG_W-1:0] head_flags;
    logic [1:0][TAG_W-1:0]  head_tag;
    logic [1:0]             head_ok = '0;

    logic [TAG_W-1:0] tag0 = '0;
    logic [TAG_W-1:0] tag1 = '0;
    logic [31:0]      seed = 32'hdff7;
    logic [31:0]      bp_rnd;
    logic             stall_on = 1'b0;
    logic             last_xfer = 1'b0;
    logic             last_src = 1'b0;
    logic             xfer;
    int               cyc = 0;
    int               errors = 0;
    int               err_mark = 0;
    int               pass_cnt = 0;
    int               fail_cnt = 0;

    fpcvt_top #(.TAG_W(TAG_W)) dut (
        .clk       (clk),
        .rst       (rst),
        .f2i_valid (f2i_valid),
        .f2i_ready (f2i_ready),
        .f2i_data  (f2i_data),
        .f2i_tag   (f2i_tag),
        .i2f_valid (i2f_valid),
        .i2f_ready (i2f_ready),
        .i2f_data  (i2f_data),
        .i2f_tag   (i2f_tag),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_flags (res_flags),
        .res_tag   (res_tag),
        .res_src   (res_src)
    );

    always #2 clk = ~clk;

    assign xfer = res_valid && res_ready;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Truncating float to integer model
    function automatic logic [63+FLAG_W:0] f2i_ref(input fp64_word_u w);
        int                e;
        real               r;
        real               t;
        logic [63:0]       d;
        logic [FLAG_W-1:0] f;
        e = int'(w.as_fp.exp) - FP64_BIAS;
        d = '0;
        f = '0;
        if (w.as_fp.exp == 11'h7ff && w.as_fp.mant != '0) begin
            f[FLAG_INVALID] = 1'b1;
        end else if (w.as_fp.exp == 11'h7ff || e > 63
                     || (e == 63 && !(w.as_fp.sign && w.as_fp.mant == '0))) begin
            d = w.as_fp.sign ? INT64_MIN_C : INT64_MAX_C;
            f[FLAG_OVERFLOW] = 1'b1;
        end else if (e == 63) begin
            // Exactly -2^63
            d = INT64_MIN_C;
        end else if (e < 0) begin
            f[FLAG_INEXACT] = !(w.as_fp.exp == '0 && w.as_fp.mant == '0);
        end else begin
            r = $bitstoreal(w);
            t = (r < 0.0) ? $ceil(r) : $floor(r);
            d = 64'(longint'(t));
            f[FLAG_INEXACT] = (t != r);
        end
        return {d, f};
    endfunction

    // Integer to float model, cut after 53 significant bits
    function automatic logic [63+FLAG_W:0] i2f_ref(input fp64_word_u w);
        logic [63:0]       mag;
        logic [63:0]       below;
        int                p;
        fp64_word_u        o;
        logic [FLAG_W-1:0] f;
        mag = w.as_int[63] ? 64'(-w.as_int) : 64'(w.as_int);
        p = -1;
        for (int i = 63; i >= 0 && p < 0; i--) begin
            if (mag[i]) begin
                p = i;
            end
        end
        o = '0;
        f = '0;
        if (p >= 0) begin
            o.as_fp.sign = w.as_int[63];
            o.as_fp.exp  = 11'(FP64_BIAS + p);
            if (p > 52) begin
                o.as_fp.mant    = 52'(mag >> (p - 52));
                below           = mag & ((64'd1 << (p - 52)) - 64'd1);
                f[FLAG_INEXACT] = (below != '0);
            end else begin
                o.as_fp.mant = 52'(mag << (52 - p));
            end
        end
        return {o, f};
    endfunction

    // Drive one request and hold it until accepted
    task automatic send(input logic src, input logic [63:0] w);
        logic rdy;
        @(negedge clk);
        if (src) begin
            i2f_valid = 1'b1;
            i2f_data  = w;
            i2f_tag   = tag1;
            exp_q1.push_back({i2f_ref(w), tag1});
            tag1++;
        end else begin
            f2i_valid = 1'b1;
            f2i_data  = w;
            f2i_tag   = tag0;
            exp_q0.push_back({f2i_ref(w), tag0});
            tag0++;
        end
        #1;
        rdy = src ? i2f_ready : f2i_ready;
        while (!rdy) begin
            @(negedge clk);
            #1;
            rdy = src ? i2f_ready : f2i_ready;
        end
        @(posedge clk);
    endtask

    task automatic stop_src(input logic src);
        @(negedge clk);
        if (src) begin
            i2f_valid = 1'b0;
        end else begin
            f2i_valid = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        while (exp_q0.size() + exp_q1.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (errors == err_mark) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %s: %s", name, (errors == err_mark) ? "ok" : "mismatches seen");
        err_mark = errors;
    endtask

    // Timeout and transfer record
    always @(posedge clk) begin
        cyc       <= cyc + 1;
        last_xfer <= xfer;
        last_src  <= res_src;
        if (cyc >= MAX_CYC) begin
            $display("timeout after %0d cycles with results still outstanding", cyc);
            $display("tests failed");
            $finish;
        end
    end

    // Retire the transferred entry and expose both heads
    always @(negedge clk) begin
        if (last_xfer && last_src && exp_q1.size() > 0) begin
            void'(exp_q1.pop_front());
        end else if (last_xfer && !last_src && exp_q0.size() > 0) begin
            void'(exp_q0.pop_front());
        end
        head_ok[0] = exp_q0.size() > 0;
        head_ok[1] = exp_q1.size() > 0;
        if (head_ok[0]) begin
            {head_data[0], head_flags[0], head_tag[0]} = exp_q0[0];
        end
        if (head_ok[1]) begin
            {head_data[1], head_flags[1], head_tag[1]} = exp_q1[0];
        end
    end

    // Random back-pressure
    always @(negedge clk) begin
        bp_rnd    = lcg_next();
        res_ready = !stall_on || bp_rnd[20];
    end

    a_reset: assert property (@(posedge clk) (rst && cyc > 0) || $fell(rst)
            |-> !res_valid && f2i_ready && i2f_ready)
        else begin
            errors++;
            $display("error reset res_valid %h f2i_ready %h i2f_ready %h",
                     $sampled(res_valid), $sampled(f2i_ready), $sampled(i2f_ready));
        end

    a_known: assert property (@(posedge clk) disable iff (rst) xfer |-> head_ok[res_src])
        else begin
            errors++;
            $display("result from source %0d arrived with no request outstanding",
                     $sampled(res_src));
        end

    a_data: assert property (@(posedge clk) disable iff (rst)
            xfer |-> res_data == head_data[res_src])
        else begin
            errors++;
            $display("error res_data expected %h got %h",
                     head_data[$sampled(res_src)], $sampled(res_data));
        end

    a_flags: assert property (@(posedge clk) disable iff (rst)
            xfer |-> res_flags == head_flags[res_src])
        else begin
            errors++;
            $display("error res_flags expected %h got %h",
                     head_flags[$sampled(res_src)], $sampled(res_flags));
        end

    a_tag: assert property (@(posedge clk) disable iff (rst)
            xfer |-> res_tag == head_tag[res_src])
        else begin
            errors++;
            $display("error res_tag expected %h got %h",
                     head_tag[$sampled(res_src)], $sampled(res_tag));
        end

    // Same source still granted means same payload
    a_stall: assert property (@(posedge clk) disable iff (rst)
            res_valid && !res_ready |=> res_valid && (res_src != $past(res_src)
            || ($stable(res_data) && $stable(res_flags) && $stable(res_tag))))
        else begin
            errors++;
            $display("stalled result was dropped or changed while res_ready was low");
        end

    a_alt: assert property (@(posedge clk) disable iff (rst)
            xfer && dut.f2i_res.valid && dut.i2f_res.valid
            |=> res_valid && res_src != $past(res_src))
        else begin
            errors++;
            $display("transfers did not alternate while both sources were waiting");
        end

    // One-cycle latency when the other side is quiet
    a_lat0: assert property (@(posedge clk) disable iff (rst)
            f2i_valid && f2i_ready && !i2f_valid && !dut.i2f_res.valid
            |=> res_valid && !res_src)
        else begin
            errors++;
            $display("float to integer result missing one cycle after acceptance");
        end

    a_lat1: assert property (@(posedge clk) disable iff (rst)
            i2f_valid && i2f_ready && !f2i_valid && !dut.f2i_res.valid
            |=> res_valid && res_src)
        else begin
            errors++;
            $display("integer to float result missing one cycle after acceptance");
        end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        finish_test("reset");

        // NaN, infinities, zeros, edges of range, tiny values
        send(1'b0, 64'h7ff8_0000_0000_0000);
        send(1'b0, 64'h7ff0_0000_0000_0000);
        send(1'b0, 64'hfff0_0000_0000_0000);
        send(1'b0, 64'h0000_0000_0000_0000);
        send(1'b0, 64'h8000_0000_0000_0000);
        send(1'b0, 64'h43e0_0000_0000_0000);
        send(1'b0, 64'hc3e0_0000_0000_0000);
        send(1'b0, 64'h3fe0_0000_0000_0000);
        send(1'b0, 64'h0000_0000_0000_0001);
        send(1'b0, 64'hbfe8_0000_0000_0000);
        stop_src(1'b0);
        finish_test("f2i_special");

        send(1'b0, 64'h3ff8_0000_0000_0000);
        send(1'b0, 64'hc004_0000_0000_0000);
        send(1'b0, 64'h4008_0000_0000_0000);
        for (int i = 0; i < N_RAND; i++) begin
            a = lcg_next();
            b = lcg_next();
            c = lcg_next();
            send(1'b0, {a[31], 11'(1019 + (a % 70)), b[19:0], c});
        end
        stop_src(1'b0);
        finish_test("f2i_normal");

        send(1'b1, 64'd0);
        send(1'b1, 64'd1);
        send(1'b1, 64'hffff_ffff_ffff_ffff);
        send(1'b1, INT64_MIN_C);
        send(1'b1, INT64_MAX_C);
        send(1'b1, 64'h0020_0000_0000_0001);
        for (int i = 0; i < N_RAND; i++) begin
            a = lcg_next();
            send(1'b1, {lcg_next(), lcg_next()} >> (a % 64));
        end
        stop_src(1'b1);
        finish_test("i2f");

        // Both ports stream while the bus stalls at random
        stall_on = 1'b1;
        fork
            begin
                for (int i = 0; i < N_BUS; i++) begin
                    send(1'b0, {lcg_next(), lcg_next()});
                end
                stop_src(1'b0);
            end
            begin
                for (int i = 0; i < N_BUS; i++) begin
                    send(1'b1, {lcg_next(), lcg_next()});
                end
                stop_src(1'b1);
            end
        join
        stall_on = 1'b0;
        finish_test("bus_contention");

        $display("summary: passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
